//--- hw/pps_time_pkg.sv
`default_nettype none

package pps_time_pkg;

    // seconds, free-running cycle time and dead-time counts
    typedef logic [31:0] word_t;

    // trim added on top of the nominal internal period
    typedef logic [15:0] trim_t;

    // programmable holdoff, upshifted before use
    typedef logic [15:0] holdoff_t;
    typedef logic [31:0] holdoff_cnt_t;

    // nominal internal period in sys_clk_i cycles
    localparam int unsigned PPS_BASE_PERIOD = 200;

    // number of all-ones bits below the holdoff setting
    localparam int unsigned HOLDOFF_SHIFT = 4;

    // first sampled high cycle of pps_i to pps_flag_o
    localparam int unsigned EXT_FLAG_LATENCY = 3;

    typedef enum logic {
        HO_IDLE,
        HO_ACTIVE
    } holdoff_state_t;

endpackage

`default_nettype wire

//--- hw/pps_src_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pps_src_if;
    import pps_time_pkg::*;

    // qualified external edge, one cycle
    logic ext_pulse;
    // external holdoff window is open
    logic in_holdoff;
    // internal generator tick, one cycle
    logic int_pulse;
    // trim currently applied by the internal generator
    trim_t trim_cur;

    modport ext_src (
        output ext_pulse,
        output in_holdoff
    );

    modport int_src (
        output int_pulse,
        output trim_cur
    );

    modport sink (
        input ext_pulse,
        input in_holdoff,
        input int_pulse,
        input trim_cur
    );

endinterface

`default_nettype wire

//--- hw/internal_pps_gen.sv
`timescale 1ns/10ps
`default_nettype none

module internal_pps_gen (
    input  logic                 sys_clk_i,
    input  logic                 runrst_i,
    input  logic                 en_i,
    input  pps_time_pkg::trim_t  trim_i,
    input  logic                 update_trim_i,
    pps_src_if.int_src           src
);
    import pps_time_pkg::*;

    word_t period_cnt;
    word_t period_last;

    // last count of the period, base plus trim minus one
    assign period_last = word_t'(PPS_BASE_PERIOD) + word_t'(src.trim_cur) - word_t'(1);

    // trim register, new value is picked up by the wrap compare
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            src.trim_cur <= '0;
        end else if (update_trim_i) begin
            src.trim_cur <= trim_i;
        end
    end

    // period counter and tick
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i || !en_i) begin
            period_cnt    <= '0;
            src.int_pulse <= 1'b0;
        end else if (period_cnt >= period_last) begin
            // >= so a shrinking trim cannot let the counter run away
            period_cnt    <= '0;
            src.int_pulse <= 1'b1;
        end else begin
            period_cnt    <= period_cnt + word_t'(1);
            src.int_pulse <= 1'b0;
        end
    end

    // tick is a single-cycle strobe
    a_int_pulse_single: assert property (
        @(posedge sys_clk_i) disable iff (runrst_i)
        src.int_pulse |=> !src.int_pulse
    ) else $error("internal_pps_gen: int_pulse high for two cycles");

endmodule

`default_nettype wire

//--- hw/ext_pps_qualifier.sv
`timescale 1ns/10ps
`default_nettype none

module ext_pps_qualifier (
    input  logic                    sys_clk_i,
    input  logic                    runrst_i,
    input  logic                    pps_i,
    input  logic                    use_ext_i,
    input  pps_time_pkg::holdoff_t  holdoff_i,
    input  logic                    pps_flag_i,
    pps_src_if.ext_src              src
);
    import pps_time_pkg::*;

    logic           pps_reg;
    logic           pps_rereg;
    logic           pps_edge;
    holdoff_state_t state;
    holdoff_cnt_t   holdoff_cnt;
    holdoff_cnt_t   holdoff_load;

    // setting upshifted with all ones below it
    assign holdoff_load = holdoff_cnt_t'({holdoff_i, {HOLDOFF_SHIFT{1'b1}}});

    // two-stage synchronizer for pps_i
    always_ff @(posedge sys_clk_i) begin
        pps_reg   <= pps_i;
        pps_rereg <= pps_reg;
    end

    // rising edge, ignored during holdoff
    assign pps_edge = pps_reg && !pps_rereg && (state == HO_IDLE);

    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            src.ext_pulse <= 1'b0;
        end else begin
            src.ext_pulse <= pps_edge;
        end
    end

    // holdoff fsm
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            state <= HO_IDLE;
        end else begin
            case (state)
                HO_IDLE: begin
                    if (use_ext_i && pps_flag_i) begin
                        state <= HO_ACTIVE;
                    end
                end
                HO_ACTIVE: begin
                    if (!use_ext_i || holdoff_cnt == '0) begin
                        state <= HO_IDLE;
                    end
                end
                default: state <= HO_IDLE;
            endcase
        end
    end

    // reloads while idle, counts down during holdoff
    always_ff @(posedge sys_clk_i) begin
        if (state == HO_IDLE) begin
            holdoff_cnt <= holdoff_load;
        end else begin
            holdoff_cnt <= holdoff_cnt - holdoff_cnt_t'(1);
        end
    end

    assign src.in_holdoff = (state == HO_ACTIVE);

    a_no_pulse_in_holdoff: assert property (
        @(posedge sys_clk_i) disable iff (runrst_i)
        src.ext_pulse |-> !src.in_holdoff
    ) else $error("ext_pps_qualifier: ext_pulse during holdoff");

endmodule

`default_nettype wire

//--- hw/pps_timekeeper.sv
`timescale 1ns/10ps
`default_nettype none

module pps_timekeeper (
    input  logic                  sys_clk_i,
    input  logic                  runrst_i,
    input  logic                  use_ext_i,
    input  logic                  trig_dead_i,
    input  logic                  load_sec_i,
    input  pps_time_pkg::word_t   sec_load_i,
    pps_src_if.sink               src,
    output logic                  pps_flag_o,
    output pps_time_pkg::word_t   cur_sec_o,
    output pps_time_pkg::word_t   cur_time_o,
    output pps_time_pkg::word_t   last_pps_o,
    output pps_time_pkg::word_t   llast_pps_o,
    output pps_time_pkg::word_t   cur_dead_o,
    output pps_time_pkg::word_t   last_dead_o,
    output pps_time_pkg::word_t   llast_dead_o
);

    logic pps_sel;

    // source select
    assign pps_sel = use_ext_i ? src.ext_pulse : src.int_pulse;

    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            pps_flag_o <= 1'b0;
        end else begin
            pps_flag_o <= pps_sel;
        end
    end

    // running second, load wins over the flag increment
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            cur_sec_o <= '0;
        end else if (load_sec_i) begin
            cur_sec_o <= sec_load_i;
        end else if (pps_flag_o) begin
            cur_sec_o <= cur_sec_o + 32'd1;
        end
    end

    // free-running cycle time and dead-time count
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            cur_time_o <= '0;
            cur_dead_o <= '0;
        end else begin
            cur_time_o <= cur_time_o + 32'd1;
            if (trig_dead_i) begin
                cur_dead_o <= cur_dead_o + 32'd1;
            end
        end
    end

    // two-deep history, shifted on every flag
    always_ff @(posedge sys_clk_i) begin
        if (runrst_i) begin
            last_pps_o   <= '0;
            llast_pps_o  <= '0;
            last_dead_o  <= '0;
            llast_dead_o <= '0;
        end else if (pps_flag_o) begin
            last_pps_o   <= cur_time_o;
            llast_pps_o  <= last_pps_o;
            last_dead_o  <= cur_dead_o;
            llast_dead_o <= last_dead_o;
        end
    end

    a_history_shift: assert property (
        @(posedge sys_clk_i) disable iff (runrst_i)
        pps_flag_o |=> (llast_pps_o == $past(last_pps_o))
    ) else $error("pps_timekeeper: llast_pps_o did not take last_pps_o");

    // both sources give single-cycle strobes
    a_flag_single: assert property (
        @(posedge sys_clk_i) disable iff (runrst_i)
        pps_flag_o |=> !pps_flag_o
    ) else $error("pps_timekeeper: pps_flag high for two cycles");

endmodule

`default_nettype wire

//--- hw/pps_time_top.sv
`timescale 1ns/10ps
`default_nettype none

module pps_time_top (
    input  logic                    sys_clk_i,
    input  logic                    runrst_i,
    input  logic                    pps_i,
    input  logic                    use_ext_i,
    input  logic                    en_int_i,
    input  logic                    trig_dead_i,
    input  logic                    update_trim_i,
    input  logic                    load_sec_i,
    input  pps_time_pkg::trim_t     trim_i,
    input  pps_time_pkg::holdoff_t  holdoff_i,
    input  pps_time_pkg::word_t     sec_load_i,
    output pps_time_pkg::trim_t     trim_o,
    output logic                    pps_pulse_o,
    output logic                    pps_flag_o,
    output pps_time_pkg::word_t     cur_sec_o,
    output pps_time_pkg::word_t     cur_time_o,
    output pps_time_pkg::word_t     last_pps_o,
    output pps_time_pkg::word_t     llast_pps_o,
    output pps_time_pkg::word_t     cur_dead_o,
    output pps_time_pkg::word_t     last_dead_o,
    output pps_time_pkg::word_t     llast_dead_o
);

    // both candidate sources into the timekeeper
    pps_src_if src_if ();

    internal_pps_gen u_intpps (
        .sys_clk_i     (sys_clk_i),
        .runrst_i      (runrst_i),
        .en_i          (en_int_i),
        .trim_i        (trim_i),
        .update_trim_i (update_trim_i),
        .src           (src_if.int_src)
    );

    // the flag comes back to start the holdoff
    ext_pps_qualifier u_extpps (
        .sys_clk_i  (sys_clk_i),
        .runrst_i   (runrst_i),
        .pps_i      (pps_i),
        .use_ext_i  (use_ext_i),
        .holdoff_i  (holdoff_i),
        .pps_flag_i (pps_flag_o),
        .src        (src_if.ext_src)
    );

    pps_timekeeper u_time (
        .sys_clk_i    (sys_clk_i),
        .runrst_i     (runrst_i),
        .use_ext_i    (use_ext_i),
        .trig_dead_i  (trig_dead_i),
        .load_sec_i   (load_sec_i),
        .sec_load_i   (sec_load_i),
        .src          (src_if.sink),
        .pps_flag_o   (pps_flag_o),
        .cur_sec_o    (cur_sec_o),
        .cur_time_o   (cur_time_o),
        .last_pps_o   (last_pps_o),
        .llast_pps_o  (llast_pps_o),
        .cur_dead_o   (cur_dead_o),
        .last_dead_o  (last_dead_o),
        .llast_dead_o (llast_dead_o)
    );

    assign trim_o      = src_if.trim_cur;
    assign pps_pulse_o = src_if.in_holdoff;

endmodule

`default_nettype wire

//--- testbench/tb_pps_time.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pps_time;
    import pps_time_pkg::*;

    // about 6000 cycles expected, limit leaves a wide margin
    localparam int unsigned CYCLE_LIMIT = 20000;
    localparam int unsigned HOLDOFF_VAL = 4;

    logic     sys_clk_i;
    logic     runrst_i;
    logic     pps_i;
    logic     use_ext_i;
    logic     en_int_i;
    logic     trig_dead_i;
    logic     update_trim_i;
    logic     load_sec_i;
    trim_t    trim_i;
    holdoff_t holdoff_i;
    word_t    sec_load_i;
    trim_t    trim_o;
    logic     pps_pulse_o;
    logic     pps_flag_o;
    word_t    cur_sec_o, cur_time_o, cur_dead_o;
    word_t    last_pps_o, llast_pps_o, last_dead_o, llast_dead_o;

    // reference counters, advanced on the rising edge from the stable inputs
    word_t ref_time;
    word_t ref_dead;
    word_t ref_sec;
    logic  flag_seen;
    int    errors;
    int    test_errors;
    int    tests_done;
    int    cycles;
    int    seed;
    string test_name;
    trim_t trim_val;
    word_t sec_val;

    pps_time_top i_dut (.*);

    always #4 sys_clk_i = ~sys_clk_i;

    task automatic report_mismatch(input string what, input word_t exp, input word_t act);
        $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        assert (exp == act) else report_mismatch(what, exp, act);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %s finished with %0d errors", test_name, errors - test_errors);
    endtask

    // returns reference time and dead count of the flag cycle
    task automatic wait_flag(output word_t t, output word_t d);
        do begin
            @(negedge sys_clk_i);
        end while (!pps_flag_o);
        t = ref_time;
        d = ref_dead;
    endtask

    // raise pps_i and expect the flag exactly at the latency
    task automatic ext_edge();
        pps_i = 1'b1;
        for (int k = 1; k <= EXT_FLAG_LATENCY; k++) begin
            @(negedge sys_clk_i);
            check_word("flag latency", word_t'(k == EXT_FLAG_LATENCY), word_t'(pps_flag_o));
        end
    endtask

    always @(negedge sys_clk_i) begin
        flag_seen <= pps_flag_o;
        trig_dead_i = 1'($random(seed));
    end

    always @(posedge sys_clk_i) begin
        if (runrst_i) begin
            ref_time <= '0;
            ref_dead <= '0;
            ref_sec  <= '0;
        end else begin
            ref_time <= ref_time + 32'd1;
            if (trig_dead_i) ref_dead <= ref_dead + 32'd1;
            if (load_sec_i) begin
                ref_sec <= sec_load_i;
            end else if (flag_seen) begin
                ref_sec <= ref_sec + 32'd1;
            end
        end
    end

    a_cur_time: assert property (@(negedge sys_clk_i) disable iff (runrst_i)
        cur_time_o == ref_time) else report_mismatch("cur_time_o", ref_time, cur_time_o);
    a_cur_dead: assert property (@(negedge sys_clk_i) disable iff (runrst_i)
        cur_dead_o == ref_dead) else report_mismatch("cur_dead_o", ref_dead, cur_dead_o);
    a_cur_sec: assert property (@(negedge sys_clk_i) disable iff (runrst_i)
        cur_sec_o == ref_sec) else report_mismatch("cur_sec_o", ref_sec, cur_sec_o);
    a_pulse_after_flag: assert property (@(negedge sys_clk_i) disable iff (runrst_i)
        (use_ext_i && pps_flag_o) |=> pps_pulse_o) else report_fail("no holdoff after flag");

    always @(posedge sys_clk_i) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        word_t t0, t1, d0, d1, s0;
        int    k;
        int    n_high;
        sys_clk_i = 1'b0;
        runrst_i = 1'b1;
        {pps_i, use_ext_i, en_int_i, trig_dead_i, update_trim_i, load_sec_i} = '0;
        trim_i = '0;
        sec_load_i = '0;
        holdoff_i = holdoff_t'(HOLDOFF_VAL);
        {errors, tests_done, cycles} = '0;
        seed = 51910;
        // keeps the trimmed period at or below 400 cycles
        trim_val = trim_t'(1 + $unsigned($random(seed)) % 199);
        sec_val = $random(seed);

        start_test("reset");
        repeat (3) @(negedge sys_clk_i);
        runrst_i = 1'b0;
        check_word("counters", 0, cur_sec_o | cur_time_o | cur_dead_o);
        check_word("history", 0, last_pps_o | llast_pps_o | last_dead_o | llast_dead_o);
        check_word("flag pulse trim", 0, word_t'({pps_flag_o, pps_pulse_o, trim_o}));
        end_test();

        start_test("internal");
        en_int_i = 1'b1;
        wait_flag(t0, d0);
        repeat (3) begin
            wait_flag(t1, d1);
            check_word("period", PPS_BASE_PERIOD, t1 - t0);
            t0 = t1;
        end
        @(negedge sys_clk_i);
        check_word("last minus llast", PPS_BASE_PERIOD, last_pps_o - llast_pps_o);
        end_test();

        start_test("trim");
        trim_i = trim_val;
        update_trim_i = 1'b1;
        @(negedge sys_clk_i);
        update_trim_i = 1'b0;
        check_word("trim_o", trim_val, trim_o);
        // period containing the update is skipped
        wait_flag(t0, d0);
        repeat (3) begin
            wait_flag(t1, d1);
            check_word("trimmed period", PPS_BASE_PERIOD + trim_val, t1 - t0);
            t0 = t1;
        end
        end_test();

        start_test("disable");
        en_int_i = 1'b0;
        repeat (2 * (PPS_BASE_PERIOD + trim_val)) begin
            @(negedge sys_clk_i);
            assert (!pps_flag_o) else report_fail("flag while the internal source is off");
        end
        end_test();

        start_test("external");
        use_ext_i = 1'b1;
        repeat (5) @(negedge sys_clk_i);
        ext_edge();
        n_high = 0;
        k = 0;
        do begin
            @(negedge sys_clk_i);
            if (k == 0) check_word("pulse after flag", 1, word_t'(pps_pulse_o));
            if (pps_pulse_o) n_high++;
            // second edge lands well inside the holdoff
            if (k == 5) pps_i = 1'b0;
            if (k == 10) pps_i = 1'b1;
            if (k == 30) pps_i = 1'b0;
            assert (!pps_flag_o) else report_fail("flag from an edge inside the holdoff");
            k++;
        end while (pps_pulse_o || k < 40);
        // load is the setting upshifted with all ones below, held for load plus one
        check_word("holdoff length", (HOLDOFF_VAL << HOLDOFF_SHIFT) + (1 << HOLDOFF_SHIFT), n_high);
        ext_edge();
        // holdoff starts in the cycle after the flag, while the external source is selected
        @(negedge sys_clk_i);
        check_word("pulse after second flag", 1, word_t'(pps_pulse_o));
        end_test();

        start_test("seconds");
        use_ext_i = 1'b0;
        en_int_i = 1'b1;
        wait_flag(t0, d0);
        @(negedge sys_clk_i);
        s0 = cur_sec_o;
        wait_flag(t0, d0);
        @(negedge sys_clk_i);
        check_word("second increment", s0 + 32'd1, cur_sec_o);
        // load strobe sampled on the same edge as the flag
        wait_flag(t0, d0);
        load_sec_i = 1'b1;
        sec_load_i = sec_val;
        @(negedge sys_clk_i);
        load_sec_i = 1'b0;
        check_word("loaded second", sec_val, cur_sec_o);
        wait_flag(t0, d0);
        @(negedge sys_clk_i);
        check_word("second after load", sec_val + 32'd1, cur_sec_o);
        end_test();

        start_test("history");
        wait_flag(t0, d0);
        repeat (3) begin
            wait_flag(t1, d1);
            @(negedge sys_clk_i);
            check_word("last_pps_o", t1, last_pps_o);
            check_word("llast_pps_o", t0, llast_pps_o);
            check_word("last_dead_o", d1, last_dead_o);
            check_word("llast_dead_o", d0, llast_dead_o);
            t0 = t1;
            d0 = d1;
        end
        end_test();

        $display("%0d tests finished, %0d errors", tests_done, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/pps_time_pkg.sv
hw/pps_src_if.sv
hw/internal_pps_gen.sv
hw/ext_pps_qualifier.sv
hw/pps_timekeeper.sv
hw/pps_time_top.sv
testbench/tb_pps_time.sv
